// File: verilog/audio_pkg.sv
// samples are signed 16-bit two's complement; a frame is always one left and one right word
package audio_pkg;

    //////////////////////////////
    // sample format
    //////////////////////////////

    localparam int SAMPLE_W = 16;   // bits per channel word

    // one signed audio word as it comes off the I2S line
    typedef logic signed [SAMPLE_W-1:0] sample_t;

    // saturation limits
    localparam sample_t SAMPLE_MAX = sample_t'({1'b0, {(SAMPLE_W-1){1'b1}}});
    localparam sample_t SAMPLE_MIN = sample_t'({1'b1, {(SAMPLE_W-1){1'b0}}});

    //////////////////////////////
    // stereo frame
    //////////////////////////////

    // left sits in the upper half, same order as on the wire
    typedef struct packed {
        sample_t left;      // ws low
        sample_t right;     // ws high
    } stereo_frame_t;

endpackage

// File: verilog/ctrl_pkg.sv
// mode codes follow the board's speaker control word; codes not listed below act as direct loop
package ctrl_pkg;

    //////////////////////////////
    // speaker mode
    //////////////////////////////

    typedef enum logic [2:0] {
        MODE_DIRECT = 3'b000,   // plain loop, also the reset mode
        MODE_IFFT   = 3'b001,   // no FFT path here, plays as direct
        MODE_L_ONLY = 3'b010,
        MODE_DECHO  = 3'b011,   // right minus scaled left
        MODE_R_ONLY = 3'b100
    } speaker_mode_t;

    //////////////////////////////
    // control word to the mixer
    //////////////////////////////

    typedef struct packed {
        speaker_mode_t mode;
        logic          mute;    // 1 = silence both channels
    } loop_ctrl_t;

endpackage

// File: verilog/loop_control.sv
// mode and mute are slow static levels; startup delay counts clk_12M cycles and saturates
`timescale 1ns/1ps

module loop_control #(
    parameter int START_DELAY = 20'h50000
) (
    input  logic                    clk_12M,
    input  logic                    i_rst,
    input  ctrl_pkg::speaker_mode_t i_mode,
    input  logic                    i_mute,
    output ctrl_pkg::loop_ctrl_t    o_ctrl,
    output logic                    o_ready
);

    localparam int CNT_W = (START_DELAY > 0) ? $clog2(START_DELAY + 1) : 1;
    localparam logic [CNT_W-1:0] CNT_END = CNT_W'(START_DELAY);

    // direct loop, muted
    localparam ctrl_pkg::loop_ctrl_t RST_CTRL = '{
        mode: ctrl_pkg::MODE_DIRECT,
        mute: 1'b1
    };

    logic [CNT_W-1:0]     start_cnt;
    ctrl_pkg::loop_ctrl_t ctrl_meta;
    ctrl_pkg::loop_ctrl_t ctrl_sync;

    //////////////////////////////
    // startup delay
    //////////////////////////////

    always_ff @(posedge clk_12M) begin
        if (i_rst) begin
            start_cnt <= '0;
        end else if (start_cnt != CNT_END) begin
            start_cnt <= start_cnt + 1'b1;   // stops at the end value
        end
    end

    assign o_ready = (start_cnt == CNT_END);

    //////////////////////////////
    // level synchronizers
    //////////////////////////////

    always_ff @(posedge clk_12M) begin
        if (i_rst) begin
            ctrl_meta <= RST_CTRL;
            ctrl_sync <= RST_CTRL;
        end else begin
            ctrl_meta <= '{mode: i_mode, mute: i_mute};
            ctrl_sync <= ctrl_meta;
        end
    end

    // audio stays silent until the codec side has settled
    always_comb begin
        o_ctrl      = ctrl_sync;
        o_ctrl.mute = ctrl_sync.mute | ~o_ready;
    end

endmodule

// File: verilog/i2s_receiver.sv
// needs sck at most clk_12M/4 and 16 bits per channel; first frame after reset lacks a left word
`timescale 1ns/1ps

module i2s_receiver (
    input  logic                      clk_12M,
    input  logic                      i_rst,
    input  logic                      i_sck,
    input  logic                      i_ws,
    input  logic                      i_sda,
    output audio_pkg::stereo_frame_t  o_frame,
    output logic                      o_frame_valid
);

    localparam int SW    = audio_pkg::SAMPLE_W;
    localparam int CNT_W = $clog2(SW + 1);
    localparam logic [CNT_W-1:0] LAST_BIT = CNT_W'(SW - 1);
    localparam logic [CNT_W-1:0] CNT_IDLE = CNT_W'(SW);

    typedef struct packed {
        logic sck;
        logic ws;
        logic sda;
    } pins_t;

    pins_t              pin_meta;
    pins_t              pin_sync;
    logic               sck_prev;
    logic               chan_r;     // channel of the word being shifted (1 = right)
    logic [CNT_W-1:0]   bit_cnt;
    audio_pkg::sample_t shift_q;
    audio_pkg::sample_t left_q;
    audio_pkg::sample_t word_in;
    logic               sck_rise;
    logic               ws_change;
    logic               word_done;

    // all three pins take the same delay so their alignment holds
    always_ff @(posedge clk_12M) begin
        if (i_rst) begin
            pin_meta <= '0;
            pin_sync <= '0;
            sck_prev <= 1'b0;
        end else begin
            pin_meta <= '{sck: i_sck, ws: i_ws, sda: i_sda};
            pin_sync <= pin_meta;
            sck_prev <= pin_sync.sck;
        end
    end

    assign sck_rise  = pin_sync.sck & ~sck_prev;
    assign ws_change = pin_sync.ws ^ chan_r;
    assign word_done = sck_rise && (bit_cnt == LAST_BIT);
    assign word_in   = {shift_q[SW-2:0], pin_sync.sda};   // incl. the bit on this edge

    //////////////////////////////
    // bit counting
    //////////////////////////////

    // the ws edge comes one bit before the MSB, so the bit taken on that
    // edge is still the LSB of the word before
    always_ff @(posedge clk_12M) begin
        if (i_rst) begin
            chan_r        <= 1'b0;
            bit_cnt       <= CNT_IDLE;
            o_frame_valid <= 1'b0;
        end else begin
            o_frame_valid <= word_done & chan_r;
            if (sck_rise) begin
                if (ws_change) begin
                    chan_r  <= pin_sync.ws;
                    bit_cnt <= '0;
                end else if (bit_cnt != CNT_IDLE) begin
                    bit_cnt <= bit_cnt + 1'b1;
                end
            end
        end
    end

    //////////////////////////////
    // data path
    //////////////////////////////

    always_ff @(posedge clk_12M) begin
        if (sck_rise) begin
            shift_q <= word_in;     // MSB first
        end
        if (word_done) begin
            if (chan_r) begin
                o_frame <= '{left: left_q, right: word_in};
            end else begin
                left_q <= word_in;  // held until the right word is in
            end
        end
    end

endmodule

// File: verilog/output_mixer.sv
// ECHO_SHIFT must be 0..15; control is taken as it stands when the frame arrives
`timescale 1ns/1ps

module output_mixer #(
    parameter int ECHO_SHIFT = 1
) (
    input  logic                     clk_12M,
    input  logic                     i_rst,
    input  audio_pkg::stereo_frame_t i_frame,
    input  logic                     i_frame_valid,
    input  ctrl_pkg::loop_ctrl_t     i_ctrl,
    output audio_pkg::stereo_frame_t o_frame,
    output logic                     o_valid
);

    localparam int SW = audio_pkg::SAMPLE_W;

    typedef logic signed [SW:0] wide_t;     // one guard bit for the subtract

    audio_pkg::sample_t       left_shr;
    audio_pkg::sample_t       decho;
    wide_t                    diff;
    audio_pkg::stereo_frame_t mix;

    //////////////////////////////
    // echo reduction
    //////////////////////////////

    always_comb begin
        left_shr = i_frame.left >>> ECHO_SHIFT;     // arithmetic, keeps sign
        diff     = {i_frame.right[SW-1], i_frame.right} - {left_shr[SW-1], left_shr};
        if (diff[SW] != diff[SW-1]) begin
            decho = diff[SW] ? audio_pkg::SAMPLE_MIN : audio_pkg::SAMPLE_MAX;
        end else begin
            decho = diff[SW-1:0];
        end
    end

    //////////////////////////////
    // mode select
    //////////////////////////////

    always_comb begin
        if (i_ctrl.mute) begin
            mix = '0;
        end else begin
            case (i_ctrl.mode)
                ctrl_pkg::MODE_L_ONLY: mix = '{left: i_frame.left, right: i_frame.left};
                ctrl_pkg::MODE_R_ONLY: mix = '{left: i_frame.right, right: i_frame.right};
                ctrl_pkg::MODE_DECHO:  mix = '{left: decho, right: decho};
                default:               mix = i_frame;  // direct, IFFT code too
            endcase
        end
    end

    always_ff @(posedge clk_12M) begin
        if (i_rst) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_frame_valid;
        end
    end

    always_ff @(posedge clk_12M) begin
        if (i_frame_valid) begin
            o_frame <= mix;
        end
    end

endmodule

// File: verilog/i2s_transmitter.sv
// DAC sck must be at or below clk_12M/4 with 16 bits per channel; sends one whole frame per ws period
`timescale 1ns/1ps

module i2s_transmitter (
    input  logic                     clk_12M,
    input  logic                     i_rst,
    input  audio_pkg::stereo_frame_t i_frame,
    input  logic                     i_valid,
    input  logic                     i_ready,
    input  logic                     i_sck,
    input  logic                     i_ws,
    output logic                     o_dac_sda
);

    localparam int SW = audio_pkg::SAMPLE_W;

    typedef struct packed {
        logic sck;
        logic ws;
    } dac_clks_t;

    dac_clks_t                clk_meta;
    dac_clks_t                clk_sync;
    logic                     sck_prev;
    logic                     ws_last;    // ws as seen on the last sck fall
    logic                     sck_fall;
    logic                     ws_change;
    logic                     sda_q;
    audio_pkg::stereo_frame_t frame_q;
    audio_pkg::sample_t       right_hold;
    audio_pkg::sample_t       shift_q;

    assign sck_fall  = ~clk_sync.sck & sck_prev;
    assign ws_change = clk_sync.ws ^ ws_last;

    //////////////////////////////
    // clock sync and line driver
    //////////////////////////////

    always_ff @(posedge clk_12M) begin
        if (i_rst) begin
            clk_meta <= '0;
            clk_sync <= '0;
            sck_prev <= 1'b0;
            ws_last  <= 1'b0;
            sda_q    <= 1'b0;
        end else begin
            clk_meta <= '{sck: i_sck, ws: i_ws};
            clk_sync <= clk_meta;
            sck_prev <= clk_sync.sck;
            if (sck_fall) begin
                ws_last <= clk_sync.ws;
            end
            if (!i_ready) begin
                sda_q <= 1'b0;                  // silent line until codec is up
            end else if (sck_fall) begin
                sda_q <= shift_q[SW-1];
            end
        end
    end

    assign o_dac_sda = sda_q;

    //////////////////////////////
    // word loading
    //////////////////////////////

    // both halves come from one snapshot taken at the left edge, so a frame
    // landing mid-period cannot mix two frames on the wire
    always_ff @(posedge clk_12M) begin
        if (i_rst) begin
            frame_q    <= '0;
            right_hold <= '0;
            shift_q    <= '0;
        end else begin
            if (i_valid) begin
                frame_q <= i_frame;             // newest frame wins
            end
            if (sck_fall) begin
                if (ws_change && clk_sync.ws) begin
                    shift_q <= right_hold;
                end else if (ws_change) begin
                    shift_q    <= frame_q.left;
                    right_hold <= frame_q.right;
                end else begin
                    shift_q <= shift_q << 1;    // next bit to the MSB
                end
            end
        end
    end

endmodule

// File: verilog/audio_loop_top.sv
// single clk_12M domain; codec pins are asynchronous and are synchronized inside the I2S blocks
`timescale 1ns/1ps

module audio_loop_top #(
    parameter int START_DELAY = 20'h50000,
    parameter int ECHO_SHIFT  = 1
) (
    input  logic                    clk_12M,
    input  logic                    i_rst,
    input  logic                    i_adc_sck,
    input  logic                    i_adc_ws,
    input  logic                    i_adc_sda,
    input  logic                    i_dac_sck,
    input  logic                    i_dac_ws,
    input  ctrl_pkg::speaker_mode_t i_mode,
    input  logic                    i_mute,
    output logic                    o_dac_sda
);

    ctrl_pkg::loop_ctrl_t     loop_ctrl;
    logic                     ready;
    audio_pkg::stereo_frame_t adc_frame;
    logic                     adc_frame_valid;
    audio_pkg::stereo_frame_t mix_frame;
    logic                     mix_valid;

    //////////////////////////////
    // control and capture
    //////////////////////////////

    loop_control #(
        .START_DELAY (START_DELAY)
    ) u_loop_control (
        .clk_12M (clk_12M),
        .i_rst   (i_rst),
        .i_mode  (i_mode),
        .i_mute  (i_mute),
        .o_ctrl  (loop_ctrl),
        .o_ready (ready)
    );

    i2s_receiver u_i2s_receiver (
        .clk_12M       (clk_12M),
        .i_rst         (i_rst),
        .i_sck         (i_adc_sck),
        .i_ws          (i_adc_ws),
        .i_sda         (i_adc_sda),
        .o_frame       (adc_frame),
        .o_frame_valid (adc_frame_valid)
    );

    //////////////////////////////
    // mix and playback
    //////////////////////////////

    output_mixer #(
        .ECHO_SHIFT (ECHO_SHIFT)
    ) u_output_mixer (
        .clk_12M       (clk_12M),
        .i_rst         (i_rst),
        .i_frame       (adc_frame),
        .i_frame_valid (adc_frame_valid),
        .i_ctrl        (loop_ctrl),
        .o_frame       (mix_frame),
        .o_valid       (mix_valid)
    );

    i2s_transmitter u_i2s_transmitter (
        .clk_12M   (clk_12M),
        .i_rst     (i_rst),
        .i_frame   (mix_frame),
        .i_valid   (mix_valid),
        .i_ready   (ready),
        .i_sck     (i_dac_sck),
        .i_ws      (i_dac_ws),
        .o_dac_sda (o_dac_sda)
    );

endmodule

// File: verif/tb_audio_loop.sv
// ADC and DAC share one codec bit clock; START_DELAY is overridden to 64
`timescale 1ns/1ps

module tb_audio_loop;

    localparam int START_DELAY  = 64;
    localparam int ECHO_SHIFT   = 1;
    localparam int NUM_SEG      = 8;
    localparam int TOTAL_FRAMES = 137;                  // sum of all segment lengths
    localparam int RUN_FRAMES   = TOTAL_FRAMES + 3;     // two frames of lag plus one to finish
    localparam int SKIP_FRAMES  = 3;
    localparam longint WATCHDOG_NS = longint'(START_DELAY + RUN_FRAMES * 256 + 1000) * 8;

    logic                     clk_12M;
    logic                     i_rst;
    logic                     sck;          // drives both ADC and DAC bit clocks
    logic                     ws;
    logic                     adc_sda;
    ctrl_pkg::speaker_mode_t  mode;
    logic                     mute;
    logic                     o_dac_sda;

    logic [31:0]              rng_state;
    logic [31:0]              dac_sr;       // DAC bits in MSB first order
    audio_pkg::stereo_frame_t exp_q[$];     // one entry per frame period
    bit                       skip_q[$];
    int                       errors;
    int                       checks;
    bit                       rst_done;
    bit                       codec_done;

    audio_loop_top #(
        .START_DELAY (START_DELAY),
        .ECHO_SHIFT  (ECHO_SHIFT)
    ) u_audio_loop_top (
        .clk_12M   (clk_12M),
        .i_rst     (i_rst),
        .i_adc_sck (sck),
        .i_adc_ws  (ws),
        .i_adc_sda (adc_sda),
        .i_dac_sck (sck),
        .i_dac_ws  (ws),
        .i_mode    (mode),
        .i_mute    (mute),
        .o_dac_sda (o_dac_sda)
    );

    initial begin
        clk_12M = 1'b0;
        forever #4 clk_12M = ~clk_12M;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before all frames were sent and checked");
        $display("SOME TESTS FAILED");
        $finish;
    end

    //////////////////////////////
    // helpers
    //////////////////////////////

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    // mixer rules applied to one ADC frame
    function automatic audio_pkg::stereo_frame_t mix_model(
        input audio_pkg::stereo_frame_t fr,
        input logic [2:0]               mode_bits,
        input logic                     mute_bit
    );
        int                       l;
        int                       r;
        int                       d;
        audio_pkg::stereo_frame_t res;
        l = $signed(fr.left);
        r = $signed(fr.right);
        d = r - (l >>> ECHO_SHIFT);
        if (d > 32767) begin
            d = 32767;
        end else if (d < -32768) begin
            d = -32768;
        end
        res = fr;       // direct and the unused IFFT code
        if (mute_bit) begin
            res = '0;
        end else if (mode_bits == 3'b010) begin
            res.right = fr.left;
        end else if (mode_bits == 3'b100) begin
            res.left = fr.right;
        end else if (mode_bits == 3'b011) begin
            res.left  = 16'(d);
            res.right = 16'(d);
        end
        return res;
    endfunction

    function automatic int seg_len(input int seg);
        case (seg)
            0:       return 4;      // startup
            6:       return 8;      // mute
            7:       return 10;     // direct after mute
            default: return 23;
        endcase
    endfunction

    // {mode, mute} per segment
    function automatic logic [3:0] seg_ctrl(input int seg);
        case (seg)
            2:       return {3'b001, 1'b0};
            3:       return {3'b010, 1'b0};
            4:       return {3'b100, 1'b0};
            5:       return {3'b011, 1'b0};
            6:       return {3'b000, 1'b1};
            default: return {3'b000, 1'b0};
        endcase
    endfunction

    task automatic check_value(input string name, input logic [15:0] expected,
                               input logic [15:0] actual);
        checks = checks + 1;
        if (actual !== expected) begin
            errors = errors + 1;
            $display("FAIL %s expected %h got %h", name, expected, actual);
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk_12M);
        #1;
    endtask

    //////////////////////////////
    // reset, startup and result
    //////////////////////////////

    initial begin
        i_rst      = 1'b1;
        sck        = 1'b0;
        ws         = 1'b0;
        adc_sda    = 1'b0;
        mode       = ctrl_pkg::MODE_DIRECT;
        mute       = 1'b0;
        errors     = 0;
        checks     = 0;
        rng_state  = 32'hca6cfc6c;
        dac_sr     = '0;
        wait_cycles(2);
        i_rst    = 1'b0;
        rst_done = 1'b1;
        repeat (START_DELAY) begin          // line must stay silent until ready
            wait_cycles(1);
            check_value("o_dac_sda", 16'd0, {15'd0, o_dac_sda});
        end
        wait (codec_done);
        $display("checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

    //////////////////////////////
    // codec pins and DAC capture
    //////////////////////////////

    initial begin : codec_model
        audio_pkg::stereo_frame_t cur;
        audio_pkg::stereo_frame_t prev;
        audio_pkg::stereo_frame_t got;
        logic [3:0]               ctrl;
        int                       seg;
        int                       seg_pos;
        int                       f;
        int                       p;
        cur     = '0;
        seg     = 0;
        seg_pos = 0;
        wait (rst_done);
        wait_cycles(1);
        for (f = 0; f < RUN_FRAMES; f++) begin
            if (seg_pos == seg_len(seg) && seg < NUM_SEG - 1) begin
                seg     = seg + 1;
                seg_pos = 0;
            end
            ctrl = seg_ctrl(seg);
            prev = cur;
            if (seg == 5 && seg_pos == 3) begin
                cur = '{left: 16'h8000, right: 16'h7fff};   // past the top
            end else if (seg == 5 && seg_pos == 4) begin
                cur = '{left: 16'h7ffe, right: 16'h8000};   // past the bottom
            end else if (seg == 5 && seg_pos == 5) begin
                cur = '{left: 16'h7fff, right: 16'hc000};   // just inside
            end else begin
                rng_state = lcg_next(rng_state);
                cur.left  = rng_state[31:16];
                rng_state = lcg_next(rng_state);
                cur.right = rng_state[31:16];
            end
            exp_q.push_back(mix_model(cur, ctrl[3:1], ctrl[0]));
            skip_q.push_back(seg_pos < SKIP_FRAMES);
            seg_pos = seg_pos + 1;

            for (p = 0; p < 32; p++) begin
                sck = 1'b0;                 // ws and data change on the fall
                ws  = (p >= 16);
                if (p == 0) begin
                    adc_sda = prev.right[0];
                end else if (p <= 16) begin
                    adc_sda = cur.left[16 - p];
                end else begin
                    adc_sda = cur.right[32 - p];
                end
                // mid-frame and away from the receiver's frame edge
                if (p == 8) begin
                    mode = ctrl_pkg::speaker_mode_t'(ctrl[3:1]);
                    mute = ctrl[0];
                end
                wait_cycles(4);
                sck    = 1'b1;
                dac_sr = {dac_sr[30:0], o_dac_sda};
                // DAC frame f-1 is complete and carries ADC frame f-3
                if (p == 0 && f >= 3 && !skip_q[f - 3]) begin
                    got = dac_sr;
                    check_value($sformatf("o_dac_sda left, frame %0d", f - 3),
                                exp_q[f - 3].left, got.left);
                    check_value($sformatf("o_dac_sda right, frame %0d", f - 3),
                                exp_q[f - 3].right, got.right);
                end
                wait_cycles(4);
            end
        end
        codec_done = 1'b1;
    end

endmodule

// File: verilog.f
verilog/audio_pkg.sv
verilog/ctrl_pkg.sv
verilog/loop_control.sv
verilog/i2s_receiver.sv
verilog/output_mixer.sv
verilog/i2s_transmitter.sv
verilog/audio_loop_top.sv
verif/tb_audio_loop.sv

// File: Bender.yml
package:
  name: audio_loop

sources:
  # packages first
  - verilog/audio_pkg.sv
  - verilog/ctrl_pkg.sv
  # design
  - verilog/loop_control.sv
  - verilog/i2s_receiver.sv
  - verilog/output_mixer.sv
  - verilog/i2s_transmitter.sv
  - verilog/audio_loop_top.sv
  # testbench
  - target: test
    files:
      - verif/tb_audio_loop.sv
